// ==== filelist.f ====
design/l2_cache_pkg.sv
design/cache_array.sv
design/plru_tree.sv
design/l2_cache_control.sv
design/l2_cache_datapath.sv
design/l2_cache.sv
test/l2_cache_props.sv
test/l2_cache_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the L2 cache testbench

VERILATOR  ?= verilator
TOP        := l2_cache_tb
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== test/l2_cache_tb.sv ====
/*
 * Testbench for the L2 cache. Random reads and writes from a fixed seed
 * are checked against a golden memory and a cache model, while a
 * line-wide memory model answers fills and write-backs.
 */
`timescale 1ns/100ps
`default_nettype none

module l2_cache_tb;

    localparam int ADDR_WIDTH         = 32;
    localparam int LINE_BITS          = 256;
    localparam int NUM_SETS           = 8;
    localparam int PERF_COUNTER_WIDTH = 16;
    localparam int NUM_BYTES          = LINE_BITS / 8;
    localparam int NUM_LINES          = 128;
    localparam int NUM_OPS            = 2000;
    localparam int CLK_PERIOD         = 40;

    logic                          clk;
    logic                          rst;
    logic                          mem_read;
    logic                          mem_write;
    logic [ADDR_WIDTH-1:0]         mem_address;
    logic [LINE_BITS-1:0]          mem_wdata;
    logic [NUM_BYTES-1:0]          mem_byte_enable;
    logic [LINE_BITS-1:0]          mem_rdata;
    logic                          mem_resp;
    logic                          pmem_read;
    logic                          pmem_write;
    logic [ADDR_WIDTH-1:0]         pmem_address;
    logic [LINE_BITS-1:0]          pmem_wdata;
    logic [LINE_BITS-1:0]          pmem_rdata;
    logic                          pmem_resp;
    logic [PERF_COUNTER_WIDTH-1:0] miss_count;

    // Architectural line contents, and what memory really holds
    logic [LINE_BITS-1:0] golden_mem [NUM_LINES];
    logic [LINE_BITS-1:0] phys_mem [NUM_LINES];

    logic [3:0]                        model_tag [NUM_SETS][l2_cache_pkg::NUM_WAYS];
    logic [l2_cache_pkg::NUM_WAYS-1:0] model_valid [NUM_SETS];
    logic [l2_cache_pkg::NUM_WAYS-1:0] model_dirty [NUM_SETS];
    logic [2:0]                        model_lru [NUM_SETS];
    int                                model_misses;

    // Memory traffic of the request in flight
    int         op_reads;
    int         op_writes;
    logic       first_is_write;
    logic [6:0] read_line;
    logic [6:0] write_line;

    logic [31:0] rng_state;

    l2_cache #(
        .ADDR_WIDTH         (ADDR_WIDTH),
        .LINE_BITS          (LINE_BITS),
        .NUM_SETS           (NUM_SETS),
        .PERF_COUNTER_WIDTH (PERF_COUNTER_WIDTH)
    ) i_dut (
        .clk             (clk),
        .rst             (rst),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_address     (mem_address),
        .mem_wdata       (mem_wdata),
        .mem_byte_enable (mem_byte_enable),
        .mem_rdata       (mem_rdata),
        .mem_resp        (mem_resp),
        .pmem_read       (pmem_read),
        .pmem_write      (pmem_write),
        .pmem_address    (pmem_address),
        .pmem_wdata      (pmem_wdata),
        .pmem_rdata      (pmem_rdata),
        .pmem_resp       (pmem_resp),
        .miss_count      (miss_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    function automatic logic [LINE_BITS-1:0] initial_line(input logic [6:0] ln);
        logic [LINE_BITS-1:0] line;
        for (int w = 0; w < LINE_BITS / 32; w++)
        begin
            line[w*32 +: 32] = 32'h9e3779b9 * (32'(ln) * 32'd8 + 32'(w) + 32'd1);
        end
        return line;
    endfunction

    // Bit 2 names the pair used last, so the victim is in the other pair
    function automatic logic [1:0] plru_victim(input logic [2:0] bits);
        if (bits[2])
            return {1'b0, ~bits[1]};
        else
            return {1'b1, ~bits[0]};
    endfunction

    function automatic logic [2:0] plru_touch(input logic [2:0] bits, input logic [1:0] way);
        logic [2:0] updated;
        updated    = bits;
        updated[2] = way[1];
        if (way[1])
            updated[0] = way[0];
        else
            updated[1] = way[0];
        return updated;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int s = 0; s < NUM_SETS; s++)
        begin
            model_valid[s] = '0;
            model_dirty[s] = '0;
            model_lru[s]   = '0;
            for (int w = 0; w < l2_cache_pkg::NUM_WAYS; w++)
                model_tag[s][w] = '0;
        end
        model_misses = 0;
        // Dirty lines are lost with the reset
        for (int l = 0; l < NUM_LINES; l++)
            golden_mem[l] = phys_mem[l];
    endtask

    task automatic check_miss_count();
        assert (miss_count == PERF_COUNTER_WIDTH'(model_misses))
            else report_mismatch($sformatf("miss_count is %0d, model counted %0d",
                                           miss_count, model_misses));
    endtask

    task automatic access_line(input logic is_write, input logic [3:0] t,
                               input logic [2:0] set_idx, input logic [4:0] offset,
                               input logic [LINE_BITS-1:0] wdata,
                               input logic [NUM_BYTES-1:0] be);
        logic [6:0]           ln;
        logic                 hit;
        logic                 found;
        logic                 expect_wb;
        logic [6:0]           victim_line;
        logic [LINE_BITS-1:0] rdata;
        int                   way;
        int                   cycles;

        ln          = {t, set_idx};
        hit         = 1'b0;
        found       = 1'b0;
        expect_wb   = 1'b0;
        victim_line = '0;
        way         = 0;
        for (int w = 0; w < l2_cache_pkg::NUM_WAYS; w++)
        begin
            if (model_valid[set_idx][w] && model_tag[set_idx][w] == t)
            begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit)
        begin
            // Empty way first, else the tree victim
            for (int w = 0; w < l2_cache_pkg::NUM_WAYS; w++)
            begin
                if (!found && !model_valid[set_idx][w])
                begin
                    found = 1'b1;
                    way   = w;
                end
            end
            if (!found)
            begin
                way         = int'(plru_victim(model_lru[set_idx]));
                expect_wb   = model_dirty[set_idx][way];
                victim_line = {model_tag[set_idx][way], set_idx};
            end
        end

        op_reads        = 0;
        op_writes       = 0;
        mem_address     = {t, 20'h00000, set_idx, offset};
        mem_read        = !is_write;
        mem_write       = is_write;
        mem_wdata       = wdata;
        mem_byte_enable = is_write ? be : '0;
        cycles          = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (!mem_resp);
        rdata = mem_rdata;
        @(posedge clk);
        #2;
        mem_read  = 1'b0;
        mem_write = 1'b0;

        if (hit)
        begin
            assert (cycles == 2 && op_reads == 0 && op_writes == 0)
                else report_mismatch($sformatf("hit on line %0d: %0d cycles, %0d/%0d rd/wr",
                                               ln, cycles, op_reads, op_writes));
        end
        else
        begin
            model_misses++;
            assert (op_reads == 1 && read_line == ln)
                else report_mismatch($sformatf("miss on line %0d: %0d fills, last from %0d",
                                               ln, op_reads, read_line));
            assert (op_writes == (expect_wb ? 1 : 0))
                else report_mismatch($sformatf("miss on line %0d: %0d write-backs",
                                               ln, op_writes));
            if (expect_wb)
            begin
                assert (write_line == victim_line && first_is_write)
                    else report_mismatch($sformatf("write-back to line %0d, expected %0d",
                                                   write_line, victim_line));
            end
            model_tag[set_idx][way]   = t;
            model_valid[set_idx][way] = 1'b1;
            model_dirty[set_idx][way] = 1'b0;
        end
        model_lru[set_idx] = plru_touch(model_lru[set_idx], 2'(way));

        if (is_write)
        begin
            model_dirty[set_idx][way] = 1'b1;
            for (int b = 0; b < NUM_BYTES; b++)
            begin
                if (be[b])
                    golden_mem[ln][b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        else
        begin
            assert (rdata == golden_mem[ln])
                else report_mismatch($sformatf("read of line %0d returned %h, expected %h",
                                               ln, rdata, golden_mem[ln]));
        end
    endtask

    // Physical memory, answering after one to four cycles
    initial
    begin : memory_model
        logic [31:0] r;
        logic [6:0]  ln;
        logic        is_wr;
        int          delay;

        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        forever
        begin
            @(negedge clk);
            if (pmem_read || pmem_write)
            begin
                ln    = {pmem_address[31:28], pmem_address[7:5]};
                is_wr = pmem_write;
                assert (pmem_address[27:8] == '0 && pmem_address[4:0] == '0)
                    else report_mismatch($sformatf("bad pmem_address 0x%08h", pmem_address));
                if (op_reads + op_writes == 0)
                    first_is_write = is_wr;
                if (is_wr)
                begin
                    op_writes++;
                    write_line = ln;
                    assert (pmem_wdata == golden_mem[ln])
                        else report_mismatch($sformatf("write-back of line %0d carries %h",
                                                       ln, pmem_wdata));
                    phys_mem[ln] = pmem_wdata;
                end
                else
                begin
                    op_reads++;
                    read_line = ln;
                end
                r     = lcg_next();
                delay = 1 + int'(r[31:30]);
                repeat (delay) @(posedge clk);
                #2;
                if (!is_wr)
                    pmem_rdata = phys_mem[ln];
                pmem_resp = 1'b1;
                @(posedge clk);
                #2;
                pmem_resp = 1'b0;
            end
        end
    end

    initial
    begin : stimulus
        logic [31:0]          r;
        logic [31:0]          r2;
        logic [LINE_BITS-1:0] wdata;
        logic [NUM_BYTES-1:0] be;
        logic [3:0]           t;
        logic [2:0]           set_idx;
        logic [3:0]           last_t;
        logic [2:0]           last_set;

        clk             = 1'b0;
        rst             = 1'b1;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_address     = '0;
        mem_wdata       = '0;
        mem_byte_enable = '0;
        rng_state       = 32'd3222;
        last_t          = '0;
        last_set        = '0;
        for (int l = 0; l < NUM_LINES; l++)
            phys_mem[l] = initial_line(7'(l));
        apply_reset();

        for (int op = 0; op < NUM_OPS; op++)
        begin
            r       = lcg_next();
            r2      = lcg_next();
            t       = r[27:24];
            set_idx = r[22:20];
            for (int w = 0; w < LINE_BITS / 32; w++)
                wdata[w*32 +: 32] = lcg_next();
            be = (r2[31:30] == 2'b00) ? '1 : lcg_next();
            // Reset halfway and revisit the last line, which has to miss
            if (op == NUM_OPS / 2)
            begin
                check_miss_count();
                apply_reset();
                t       = last_t;
                set_idx = last_set;
            end
            if (r[13:12] == 2'b00)
            begin
                @(posedge clk);
                #2;
            end
            access_line(r[31], t, set_idx, r[18:14], wdata, be);
            last_t   = t;
            last_set = set_idx;
        end
        check_miss_count();

        $display("ALL TESTS PASSED");
        $finish;
    end

    initial
    begin : watchdog
        #(NUM_OPS * 16 * CLK_PERIOD);
        abort_run("Timeout: the cache stopped responding before all operations completed");
    end

endmodule : l2_cache_tb

`default_nettype wire

// ==== test/l2_cache_props.sv ====
/*
 * Protocol assertions for the L2 cache, bound into the top level
 * and sampled on every rising clock edge.
 */
`timescale 1ns/100ps
`default_nettype none

module l2_cache_props (
    input logic clk,
    input logic rst,
    input logic mem_read,
    input logic mem_write,
    input logic mem_resp,
    input logic pmem_read,
    input logic pmem_write
);

    // One memory transaction at a time
    pmem_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(pmem_read && pmem_write))
    else
        $error("pmem_read and pmem_write asserted together");

    resp_needs_request: assert property (@(posedge clk) disable iff (rst)
        mem_resp |-> (mem_read || mem_write))
    else
        $error("mem_resp asserted without a request");

    // Controller sits in IDLE once reset has been seen
    quiet_in_reset: assert property (@(posedge clk)
        rst |=> !(mem_resp || pmem_read || pmem_write))
    else
        $error("control output active during reset");

endmodule : l2_cache_props

bind l2_cache l2_cache_props i_props (.*);

`default_nettype wire

// ==== design/l2_cache.sv ====
/*
 * L2 cache top level. Four-way, write-back, write-allocate with
 * pseudo-LRU. Connects the controller to the datapath.
 */
`timescale 1ns/100ps
`default_nettype none

module l2_cache #(
    parameter int ADDR_WIDTH         = 32,
    parameter int LINE_BITS          = 256,
    parameter int NUM_SETS           = 8,
    parameter int PERF_COUNTER_WIDTH = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          mem_read,
    input  logic                          mem_write,
    input  logic [ADDR_WIDTH-1:0]         mem_address,
    input  logic [LINE_BITS-1:0]          mem_wdata,
    input  logic [LINE_BITS/8-1:0]        mem_byte_enable,
    output logic [LINE_BITS-1:0]          mem_rdata,
    output logic                          mem_resp,
    output logic                          pmem_read,
    output logic                          pmem_write,
    output logic [ADDR_WIDTH-1:0]         pmem_address,
    output logic [LINE_BITS-1:0]          pmem_wdata,
    input  logic [LINE_BITS-1:0]          pmem_rdata,
    input  logic                          pmem_resp,
    output logic [PERF_COUNTER_WIDTH-1:0] miss_count
);

    logic [l2_cache_pkg::NUM_WAYS-1:0]         hit_way;
    logic [l2_cache_pkg::NUM_WAYS-1:0]         valid_bits;
    logic [l2_cache_pkg::NUM_WAYS-1:0]         dirty_bits;
    logic [l2_cache_pkg::LRU_BITS-1:0]         lru_bits;
    logic [l2_cache_pkg::NUM_WAYS-1:0]         valid_load;
    logic                                      valid_datain;
    logic [l2_cache_pkg::NUM_WAYS-1:0]         dirty_load;
    logic                                      dirty_datain;
    logic [l2_cache_pkg::NUM_WAYS-1:0]         tag_load;
    logic [l2_cache_pkg::NUM_WAYS-1:0]         data_load;
    l2_cache_pkg::data_src_t                   data_src;
    logic                                      lru_load;
    logic [l2_cache_pkg::LRU_BITS-1:0]         lru_datain;
    logic                                      buffer_load;
    logic [$clog2(l2_cache_pkg::NUM_WAYS)-1:0] dataout_sel;
    l2_cache_pkg::pmem_addr_sel_t              pmem_addr_sel;

    l2_cache_control #(
        .PERF_COUNTER_WIDTH (PERF_COUNTER_WIDTH)
    ) i_control (.*);

    l2_cache_datapath #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .LINE_BITS  (LINE_BITS),
        .NUM_SETS   (NUM_SETS)
    ) i_datapath (.*);

endmodule : l2_cache

`default_nettype wire

// ==== design/l2_cache_datapath.sv ====
/*
 * L2 cache datapath. Holds tag and line arrays, per-set valid, dirty
 * and LRU bits and the fill buffer. Steered entirely by the controller.
 */
`timescale 1ns/100ps
`default_nettype none

module l2_cache_datapath #(
    parameter int ADDR_WIDTH = 32,
    parameter int LINE_BITS  = 256,
    parameter int NUM_SETS   = 8
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [ADDR_WIDTH-1:0]                     mem_address,
    input  logic [LINE_BITS-1:0]                      mem_wdata,
    input  logic [LINE_BITS/8-1:0]                    mem_byte_enable,
    output logic [LINE_BITS-1:0]                      mem_rdata,
    input  logic [LINE_BITS-1:0]                      pmem_rdata,
    output logic [ADDR_WIDTH-1:0]                     pmem_address,
    output logic [LINE_BITS-1:0]                      pmem_wdata,
    output logic [l2_cache_pkg::NUM_WAYS-1:0]         hit_way,
    output logic [l2_cache_pkg::NUM_WAYS-1:0]         valid_bits,
    output logic [l2_cache_pkg::NUM_WAYS-1:0]         dirty_bits,
    output logic [l2_cache_pkg::LRU_BITS-1:0]         lru_bits,
    input  logic [l2_cache_pkg::NUM_WAYS-1:0]         valid_load,
    input  logic                                      valid_datain,
    input  logic [l2_cache_pkg::NUM_WAYS-1:0]         dirty_load,
    input  logic                                      dirty_datain,
    input  logic [l2_cache_pkg::NUM_WAYS-1:0]         tag_load,
    input  logic [l2_cache_pkg::NUM_WAYS-1:0]         data_load,
    input  l2_cache_pkg::data_src_t                   data_src,
    input  logic                                      lru_load,
    input  logic [l2_cache_pkg::LRU_BITS-1:0]         lru_datain,
    input  logic                                      buffer_load,
    input  logic [$clog2(l2_cache_pkg::NUM_WAYS)-1:0] dataout_sel,
    input  l2_cache_pkg::pmem_addr_sel_t              pmem_addr_sel
);

    localparam int NUM_BYTES    = LINE_BITS / 8;
    localparam int OFFSET_WIDTH = $clog2(NUM_BYTES);
    localparam int INDEX_WIDTH  = $clog2(NUM_SETS);
    localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    logic [TAG_WIDTH-1:0]               tag;
    logic [INDEX_WIDTH-1:0]             index;
    logic [TAG_WIDTH-1:0]               tag_out [l2_cache_pkg::NUM_WAYS];
    logic [LINE_BITS-1:0]               line_out [l2_cache_pkg::NUM_WAYS];
    logic [LINE_BITS-1:0]               sel_line;
    logic [LINE_BITS-1:0]               merged_line;
    logic [LINE_BITS-1:0]               line_datain;
    logic [LINE_BITS-1:0]               fill_buf;
    logic [l2_cache_pkg::NUM_WAYS-1:0]  valid_q [NUM_SETS];
    logic [l2_cache_pkg::NUM_WAYS-1:0]  dirty_q [NUM_SETS];
    logic [l2_cache_pkg::LRU_BITS-1:0]  lru_q [NUM_SETS];

    assign tag   = mem_address[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign index = mem_address[OFFSET_WIDTH +: INDEX_WIDTH];

    assign line_datain = (data_src == l2_cache_pkg::cpu_write_cache) ? merged_line : fill_buf;

    for (genvar w = 0; w < l2_cache_pkg::NUM_WAYS; w++)
    begin : g_way
        cache_array #(
            .entry_t  (logic [TAG_WIDTH-1:0]),
            .NUM_SETS (NUM_SETS)
        ) i_tag_array (
            .clk     (clk),
            .load    (tag_load[w]),
            .index   (index),
            .datain  (tag),
            .dataout (tag_out[w])
        );

        cache_array #(
            .entry_t  (logic [LINE_BITS-1:0]),
            .NUM_SETS (NUM_SETS)
        ) i_data_array (
            .clk     (clk),
            .load    (data_load[w] && data_src != l2_cache_pkg::no_write),
            .index   (index),
            .datain  (line_datain),
            .dataout (line_out[w])
        );

        assign hit_way[w] = valid_q[index][w] && (tag_out[w] == tag);
    end

    // Per-set status bits
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < NUM_SETS; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                lru_q[s]   <= '0;
            end
        end
        else
        begin
            for (int w = 0; w < l2_cache_pkg::NUM_WAYS; w++)
            begin
                if (valid_load[w])
                    valid_q[index][w] <= valid_datain;
                if (dirty_load[w])
                    dirty_q[index][w] <= dirty_datain;
            end
            if (lru_load)
                lru_q[index] <= lru_datain;
        end
    end

    assign valid_bits = valid_q[index];
    assign dirty_bits = dirty_q[index];
    assign lru_bits   = lru_q[index];

    always_ff @(posedge clk)
    begin
        if (buffer_load)
            fill_buf <= pmem_rdata;
    end

    assign sel_line   = line_out[dataout_sel];
    assign mem_rdata  = sel_line;
    assign pmem_wdata = sel_line;

    // Requester bytes over the hit line
    always_comb
    begin : byte_merge
        for (int b = 0; b < NUM_BYTES; b++)
        begin
            merged_line[b*8 +: 8] = mem_byte_enable[b] ? mem_wdata[b*8 +: 8]
                                                       : sel_line[b*8 +: 8];
        end
    end

    always_comb
    begin : pmem_addr_mux
        if (pmem_addr_sel == l2_cache_pkg::cache_write_mem)
            pmem_address = {tag_out[dataout_sel], index, {OFFSET_WIDTH{1'b0}}};
        else
            pmem_address = {tag, index, {OFFSET_WIDTH{1'b0}}};
    end

endmodule : l2_cache_datapath

`default_nettype wire

// ==== design/l2_cache_control.sv ====
/*
 * L2 cache controller. Sequences lookup, write-back, fill and the
 * hit response, drives the datapath loads and counts lookup misses.
 */
`timescale 1ns/100ps
`default_nettype none

module l2_cache_control #(
    parameter int PERF_COUNTER_WIDTH = 16
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      mem_read,
    input  logic                                      mem_write,
    output logic                                      mem_resp,
    input  logic                                      pmem_resp,
    output logic                                      pmem_read,
    output logic                                      pmem_write,
    input  logic [l2_cache_pkg::NUM_WAYS-1:0]         hit_way,
    input  logic [l2_cache_pkg::NUM_WAYS-1:0]         valid_bits,
    input  logic [l2_cache_pkg::NUM_WAYS-1:0]         dirty_bits,
    input  logic [l2_cache_pkg::LRU_BITS-1:0]         lru_bits,
    output logic [l2_cache_pkg::NUM_WAYS-1:0]         valid_load,
    output logic                                      valid_datain,
    output logic [l2_cache_pkg::NUM_WAYS-1:0]         dirty_load,
    output logic                                      dirty_datain,
    output logic [l2_cache_pkg::NUM_WAYS-1:0]         tag_load,
    output logic [l2_cache_pkg::NUM_WAYS-1:0]         data_load,
    output l2_cache_pkg::data_src_t                   data_src,
    output logic                                      lru_load,
    output logic [l2_cache_pkg::LRU_BITS-1:0]         lru_datain,
    output logic                                      buffer_load,
    output logic [$clog2(l2_cache_pkg::NUM_WAYS)-1:0] dataout_sel,
    output l2_cache_pkg::pmem_addr_sel_t              pmem_addr_sel,
    output logic [PERF_COUNTER_WIDTH-1:0]             miss_count
);

    localparam int WAY_IDX_WIDTH = $clog2(l2_cache_pkg::NUM_WAYS);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITE_BACK,
        FILL_READ,
        FILL_WRITE
    } state_t;

    state_t state, next_state;

    logic                              hit;
    logic [WAY_IDX_WIDTH-1:0]          hit_idx;
    logic [WAY_IDX_WIDTH-1:0]          lru_victim;
    logic [WAY_IDX_WIDTH-1:0]          repl_way;
    logic [l2_cache_pkg::LRU_BITS-1:0] lru_touched;
    logic                              miss_count_en;

    assign hit = |hit_way;

    always_comb
    begin : hit_encode
        hit_idx = '0;
        for (int w = 0; w < l2_cache_pkg::NUM_WAYS; w++)
        begin
            if (hit_way[w])
            begin
                hit_idx = WAY_IDX_WIDTH'(w);
            end
        end
    end

    plru_tree i_plru_tree (
        .lru_bits    (lru_bits),
        .touched_way (hit_idx),
        .lru_next    (lru_touched),
        .victim_way  (lru_victim)
    );

    // First invalid way, else the tree victim. Once write-back clears
    // the victim's valid bit it becomes the first invalid way
    always_comb
    begin : repl_select
        repl_way = lru_victim;
        for (int w = l2_cache_pkg::NUM_WAYS - 1; w >= 0; w--)
        begin
            if (!valid_bits[w])
            begin
                repl_way = WAY_IDX_WIDTH'(w);
            end
        end
    end

    always_comb
    begin : state_actions
        mem_resp      = 1'b0;
        pmem_read     = 1'b0;
        pmem_write    = 1'b0;
        valid_load    = '0;
        valid_datain  = 1'b0;
        dirty_load    = '0;
        dirty_datain  = 1'b0;
        tag_load      = '0;
        data_load     = '0;
        data_src      = l2_cache_pkg::no_write;
        lru_load      = 1'b0;
        lru_datain    = lru_bits;
        buffer_load   = 1'b0;
        dataout_sel   = hit_idx;
        pmem_addr_sel = l2_cache_pkg::cache_read_mem;
        miss_count_en = 1'b0;

        case (state)
            LOOKUP:
            begin
                if (hit)
                begin
                    mem_resp   = 1'b1;
                    lru_load   = 1'b1;
                    lru_datain = lru_touched;
                    if (mem_write)
                    begin
                        data_load[hit_idx]  = 1'b1;
                        data_src            = l2_cache_pkg::cpu_write_cache;
                        dirty_load[hit_idx] = 1'b1;
                        dirty_datain        = 1'b1;
                    end
                end
                else
                begin
                    miss_count_en = 1'b1;
                end
            end
            WRITE_BACK:
            begin
                pmem_write           = 1'b1;
                pmem_addr_sel        = l2_cache_pkg::cache_write_mem;
                dataout_sel          = repl_way;
                valid_load[repl_way] = 1'b1;
            end
            FILL_READ:
            begin
                pmem_read   = 1'b1;
                buffer_load = pmem_resp;
            end
            FILL_WRITE:
            begin
                tag_load[repl_way]   = 1'b1;
                valid_load[repl_way] = 1'b1;
                valid_datain         = 1'b1;
                dirty_load[repl_way] = 1'b1;
                data_load[repl_way]  = 1'b1;
                data_src             = l2_cache_pkg::mem_write_cache;
            end
            default:
            begin
            end
        endcase
    end

    always_comb
    begin : next_state_logic
        next_state = state;
        case (state)
            IDLE:
            begin
                if (mem_read || mem_write)
                    next_state = LOOKUP;
            end
            LOOKUP:
            begin
                if (hit)
                    next_state = IDLE;
                else if (valid_bits[repl_way] && dirty_bits[repl_way])
                    next_state = WRITE_BACK;
                else
                    next_state = FILL_READ;
            end
            WRITE_BACK:
            begin
                if (pmem_resp)
                    next_state = FILL_READ;
            end
            FILL_READ:
            begin
                if (pmem_resp)
                    next_state = FILL_WRITE;
            end
            default:
            begin
                next_state = LOOKUP;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= IDLE;
        else
            state <= next_state;
    end

    // Saturating miss counter
    always_ff @(posedge clk)
    begin
        if (rst)
            miss_count <= '0;
        else if (miss_count_en && miss_count != '1)
            miss_count <= miss_count + PERF_COUNTER_WIDTH'(1);
    end

endmodule : l2_cache_control

`default_nettype wire

// ==== design/plru_tree.sv ====
/*
 * Tree pseudo-LRU for four ways. Gives the bits after a touch
 * and the victim way for the current bits. Purely combinational.
 */
`timescale 1ns/100ps
`default_nettype none

module plru_tree (
    input  logic [l2_cache_pkg::LRU_BITS-1:0]         lru_bits,
    input  logic [$clog2(l2_cache_pkg::NUM_WAYS)-1:0] touched_way,
    output logic [l2_cache_pkg::LRU_BITS-1:0]         lru_next,
    output logic [$clog2(l2_cache_pkg::NUM_WAYS)-1:0] victim_way
);

    // Bit 2 picks the pair, bit 1 orders ways 0/1, bit 0 orders ways 2/3
    always_comb
    begin : touch_update
        case (touched_way)
            2'd0:    lru_next = {1'b0, 1'b0, lru_bits[0]};
            2'd1:    lru_next = {1'b0, 1'b1, lru_bits[0]};
            2'd2:    lru_next = {1'b1, lru_bits[1], 1'b0};
            default: lru_next = {1'b1, lru_bits[1], 1'b1};
        endcase
    end

    // Walk away from the recently touched side
    always_comb
    begin : victim_select
        if (lru_bits[2] == 1'b0)
        begin
            victim_way = lru_bits[0] ? 2'd2 : 2'd3;
        end
        else
        begin
            victim_way = lru_bits[1] ? 2'd0 : 2'd1;
        end
    end

endmodule : plru_tree

`default_nettype wire

// ==== design/cache_array.sv ====
/*
 * Per-set storage with combinational read and clocked write.
 * The entry type is a parameter, so tags and data lines share it.
 */
`timescale 1ns/100ps
`default_nettype none

module cache_array #(
    parameter type entry_t = logic,
    parameter int  NUM_SETS = 8
) (
    input  logic                        clk,
    input  logic                        load,
    input  logic [$clog2(NUM_SETS)-1:0] index,
    input  entry_t                      datain,
    output entry_t                      dataout
);

    entry_t entries [NUM_SETS];

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            entries[index] <= datain;
        end
    end

    assign dataout = entries[index];

endmodule : cache_array

`default_nettype wire

// ==== design/l2_cache_pkg.sv ====
/*
 * Shared constants and select encodings for the L2 cache.
 * Control and datapath refer to these by scoped names.
 */
`default_nettype none

package l2_cache_pkg;

    // Four ways, fixed by the 3-bit tree
    localparam int NUM_WAYS = 4;
    localparam int LRU_BITS = 3;

    // Source of a data array write
    typedef enum logic [1:0] {
        no_write,
        cpu_write_cache,
        mem_write_cache
    } data_src_t;

    // Memory address source
    typedef enum logic {
        cache_read_mem,
        cache_write_mem
    } pmem_addr_sel_t;

endpackage : l2_cache_pkg

`default_nettype wire
